/* rtl/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// ==========================================================
// Execute stage widths
// ==========================================================

// Data and address width of the integer datapath
`define EX_XLEN 32

// Register index width, 32 architectural registers
`define EX_REG_W 5

// Byte lanes in one data word
`define EX_BYTES 4

// ==========================================================
// Constants
// ==========================================================

// Canonical no-operation, ADDI x0, x0, 0
// Loaded into the MA register on reset or flush
`define EX_NOP 32'h0000_0013

// Destination index held in the MA register after reset or flush
// Register x0 is never written, so it marks an empty slot
`define EX_RST_RD 5'd0

`endif

/* rtl/ex_pkg.sv */
package ex_pkg;

  // ==========================================================
  // ALU operations
  // ==========================================================

  // Integer operations of RV32I as seen by the ALU
  // LINK gives the return address pc + 4 for JAL and JALR
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    SLL   = 4'd2,
    SLT   = 4'd3,
    SLTU  = 4'd4,
    XOR   = 4'd5,
    SRL   = 4'd6,
    SRA   = 4'd7,
    OR    = 4'd8,
    AND   = 4'd9,
    LUI   = 4'd10,
    AUIPC = 4'd11,
    LINK  = 4'd12
  } alu_op_t;

  // ==========================================================
  // Control transfer
  // ==========================================================

  // Conditional branches and unconditional jumps
  // NONE marks an instruction that never changes the pc
  typedef enum logic [3:0] {
    NONE = 4'd0,
    BEQ  = 4'd1,
    BNE  = 4'd2,
    BLT  = 4'd3,
    BGE  = 4'd4,
    BLTU = 4'd5,
    BGEU = 4'd6,
    JAL  = 4'd7,
    JALR = 4'd8
  } branch_op_t;

  // ==========================================================
  // Memory access and traps
  // ==========================================================

  // Access size, same as the low funct3 bits of loads and stores
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } mem_size_t;

  // Synchronous exception codes as written to mcause
  typedef enum logic [3:0] {
    BREAKPOINT       = 4'd3,
    LOAD_MISALIGNED  = 4'd4,
    STORE_MISALIGNED = 4'd6,
    ECALL            = 4'd11
  } exc_cause_t;

endpackage : ex_pkg

/* rtl/ex_alu.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_alu (
  input  ex_pkg::alu_op_t       i_op,
  input  logic [`EX_XLEN-1:0]   i_operand_a,
  input  logic [`EX_XLEN-1:0]   i_operand_b,
  input  logic [`EX_XLEN-1:0]   i_imm,
  input  logic [`EX_XLEN-1:0]   i_pc,
  input  logic                  i_use_imm,
  input  logic                  i_writes_rd,
  input  logic [`EX_REG_W-1:0]  i_rd,
  output logic [`EX_XLEN-1:0]   o_result,
  output logic                  o_rd_we
);

  // ==========================================================
  // Operand selection
  // ==========================================================

  // I-type instructions take the immediate, R-type take rs2
  logic [`EX_XLEN-1:0] op_b;
  // Shift amount from the low five bits of the second operand
  logic [4:0]          shamt;
  // Compare results, widened to a full word below
  logic                lt_signed;
  logic                lt_unsigned;

  assign op_b        = i_use_imm ? i_imm : i_operand_b;
  assign shamt       = op_b[4:0];
  assign lt_signed   = $signed(i_operand_a) < $signed(op_b);
  assign lt_unsigned = i_operand_a < op_b;

  // ==========================================================
  // Result mux
  // ==========================================================

  always_comb begin
    o_result = '0;
    case (i_op)
      ex_pkg::ADD:   o_result = i_operand_a + op_b;
      ex_pkg::SUB:   o_result = i_operand_a - op_b;
      ex_pkg::SLL:   o_result = i_operand_a << shamt;
      ex_pkg::SLT: begin
        o_result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
      end
      ex_pkg::SLTU: begin
        o_result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
      end
      ex_pkg::XOR:   o_result = i_operand_a ^ op_b;
      ex_pkg::SRL:   o_result = i_operand_a >> shamt;
      // Arithmetic shift keeps the sign of rs1
      ex_pkg::SRA:   o_result = $unsigned($signed(i_operand_a) >>> shamt);
      ex_pkg::OR:    o_result = i_operand_a | op_b;
      ex_pkg::AND:   o_result = i_operand_a & op_b;
      // Decode has already placed the U-type immediate in the upper bits
      ex_pkg::LUI:   o_result = i_imm;
      ex_pkg::AUIPC: o_result = i_pc + i_imm;
      // Return address for JAL and JALR
      ex_pkg::LINK:  o_result = i_pc + `EX_XLEN'd4;
      default:       o_result = '0;
    endcase
  end

  // ==========================================================
  // Destination write enable
  // ==========================================================

  // Writes to x0 are dropped here so later stages never see them
  assign o_rd_we = i_writes_rd && (i_rd != `EX_REG_W'd0);

endmodule : ex_alu

/* rtl/branch_resolver.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module branch_resolver (
  input  ex_pkg::branch_op_t   i_op,
  input  logic [`EX_XLEN-1:0]  i_rs1,
  input  logic [`EX_XLEN-1:0]  i_rs2,
  input  logic [`EX_XLEN-1:0]  i_pc,
  input  logic [`EX_XLEN-1:0]  i_imm,
  input  logic [`EX_XLEN-1:0]  i_pred_target,
  input  logic                 i_pred_taken,
  output logic                 o_redirect,
  output logic [`EX_XLEN-1:0]  o_redirect_pc
);

  // ==========================================================
  // Condition evaluation
  // ==========================================================

  logic                taken;
  logic [`EX_XLEN-1:0] target;
  logic [`EX_XLEN-1:0] jalr_sum;
  logic [`EX_XLEN-1:0] seq_pc;
  // Comparator outputs shared by all branch types
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                target_miss;

  assign eq   = i_rs1 == i_rs2;
  assign lt_s = $signed(i_rs1) < $signed(i_rs2);
  assign lt_u = i_rs1 < i_rs2;

  always_comb begin
    taken = 1'b0;
    case (i_op)
      ex_pkg::BEQ:  taken = eq;
      ex_pkg::BNE:  taken = !eq;
      ex_pkg::BLT:  taken = lt_s;
      ex_pkg::BGE:  taken = !lt_s;
      ex_pkg::BLTU: taken = lt_u;
      ex_pkg::BGEU: taken = !lt_u;
      // Jumps always leave the sequential path
      ex_pkg::JAL:  taken = 1'b1;
      ex_pkg::JALR: taken = 1'b1;
      default:      taken = 1'b0;
    endcase
  end

  // ==========================================================
  // Target computation
  // ==========================================================

  // JALR is register relative and drops bit 0 of the sum
  assign jalr_sum = i_rs1 + i_imm;
  // Branches and JAL are pc relative
  assign target   = (i_op == ex_pkg::JALR) ?
                    {jalr_sum[`EX_XLEN-1:1], 1'b0} :
                    (i_pc + i_imm);
  assign seq_pc   = i_pc + `EX_XLEN'd4;

  // ==========================================================
  // Prediction check
  // ==========================================================

  // A correct direction can still carry a wrong target
  assign target_miss   = taken && i_pred_taken && (target != i_pred_target);
  assign o_redirect    = (taken != i_pred_taken) || target_miss;
  // Fall through to pc + 4 when a predicted-taken branch is not taken
  assign o_redirect_pc = taken ? target : seq_pc;

endmodule : branch_resolver

/* rtl/store_unit.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module store_unit (
  input  logic [`EX_XLEN-1:0]   i_rs1,
  input  logic [`EX_XLEN-1:0]   i_rs2,
  input  logic [`EX_XLEN-1:0]   i_imm,
  input  logic                  i_is_store,
  input  ex_pkg::mem_size_t     i_size,
  output logic [`EX_XLEN-1:0]   o_addr,
  output logic [`EX_XLEN-1:0]   o_wdata,
  output logic [`EX_BYTES-1:0]  o_be
);

  // Effective address, shared by loads and stores
  assign o_addr = i_rs1 + i_imm;

  // ==========================================================
  // Write data lane replication
  // ==========================================================

  // Memory picks the live lanes from the byte enables,
  // so the data is copied to every lane it could land in
  always_comb begin
    case (i_size)
      ex_pkg::BYTE: o_wdata = {4{i_rs2[7:0]}};
      ex_pkg::HALF: o_wdata = {2{i_rs2[15:0]}};
      default:      o_wdata = i_rs2;
    endcase
  end

  // ==========================================================
  // Byte enables
  // ==========================================================

  always_comb begin
    o_be = '0;
    if (i_is_store) begin
      case (i_size)
        // Single lane picked by the two low address bits
        ex_pkg::BYTE: o_be = 4'b0001 << o_addr[1:0];
        // Upper or lower half picked by address bit 1
        ex_pkg::HALF: o_be = o_addr[1] ? 4'b1100 : 4'b0011;
        default:      o_be = 4'b1111;
      endcase
    end
  end

endmodule : store_unit

/* rtl/exception_detector.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module exception_detector (
  input  logic                 i_is_ecall,
  input  logic                 i_is_ebreak,
  input  logic                 i_is_load,
  input  logic                 i_is_store,
  input  ex_pkg::mem_size_t    i_size,
  input  logic [`EX_XLEN-1:0]  i_pc,
  input  logic [`EX_XLEN-1:0]  i_addr,
  output logic                 o_valid,
  output ex_pkg::exc_cause_t   o_cause,
  output logic [`EX_XLEN-1:0]  o_tval
);

  // ==========================================================
  // Alignment check
  // ==========================================================

  logic misaligned;

  // Byte accesses are always aligned
  always_comb begin
    case (i_size)
      ex_pkg::BYTE: misaligned = 1'b0;
      ex_pkg::HALF: misaligned = i_addr[0];
      default:      misaligned = |i_addr[1:0];
    endcase
  end

  // ==========================================================
  // Cause priority
  // ==========================================================

  // ECALL first, then EBREAK, then load and store misalignment
  always_comb begin
    o_valid = 1'b1;
    o_cause = ex_pkg::ECALL;
    o_tval  = '0;
    if (i_is_ecall) begin
      o_cause = ex_pkg::ECALL;
    end else if (i_is_ebreak) begin
      // Trap value is the pc of the EBREAK itself
      o_cause = ex_pkg::BREAKPOINT;
      o_tval  = i_pc;
    end else if (i_is_load && misaligned) begin
      o_cause = ex_pkg::LOAD_MISALIGNED;
      o_tval  = i_addr;
    end else if (i_is_store && misaligned) begin
      o_cause = ex_pkg::STORE_MISALIGNED;
      o_tval  = i_addr;
    end else begin
      o_valid = 1'b0;
    end
  end

endmodule : exception_detector

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Decoded instruction and forwarded operands
  input  logic [`EX_XLEN-1:0]   i_pc,
  input  logic [`EX_XLEN-1:0]   i_rs1,
  input  logic [`EX_XLEN-1:0]   i_rs2,
  input  logic [`EX_XLEN-1:0]   i_imm,
  input  logic                  i_use_imm,
  input  ex_pkg::alu_op_t       i_alu_op,
  input  ex_pkg::branch_op_t    i_branch_op,
  // Fetch prediction for this instruction
  input  logic                  i_pred_taken,
  input  logic [`EX_XLEN-1:0]   i_pred_target,
  // Memory access type
  input  logic                  i_is_load,
  input  logic                  i_is_store,
  input  ex_pkg::mem_size_t     i_mem_size,
  input  logic                  i_load_unsigned,
  input  logic                  i_is_ecall,
  input  logic                  i_is_ebreak,
  input  logic [`EX_REG_W-1:0]  i_rd,
  input  logic                  i_writes_rd,
  input  logic [`EX_XLEN-1:0]   i_instr,
  // Pipeline control levels
  input  logic                  i_stall,
  input  logic                  i_flush,
  // Same-cycle results toward fetch, memory and trap logic
  output logic                  o_redirect,
  output logic [`EX_XLEN-1:0]   o_redirect_pc,
  output logic [`EX_XLEN-1:0]   o_mem_addr,
  output logic [`EX_BYTES-1:0]  o_mem_be,
  output logic [`EX_XLEN-1:0]   o_mem_wdata,
  output logic                  o_exc_valid,
  output ex_pkg::exc_cause_t    o_exc_cause,
  output logic [`EX_XLEN-1:0]   o_exc_tval,
  // MA pipeline register
  output logic [`EX_XLEN-1:0]   o_ma_result,
  output logic [`EX_XLEN-1:0]   o_ma_mem_addr,
  output logic [`EX_XLEN-1:0]   o_ma_rs2,
  output logic                  o_ma_rd_we,
  output logic [`EX_REG_W-1:0]  o_ma_rd,
  output logic [`EX_XLEN-1:0]   o_ma_instr,
  output logic                  o_ma_is_load,
  output ex_pkg::mem_size_t     o_ma_mem_size,
  output logic                  o_ma_load_unsigned
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                rd_we;
  logic [`EX_XLEN-1:0] mem_addr;

  // ==========================================================
  // Execute units
  // ==========================================================

  ex_alu ex_alu_inst (
    .i_op        (i_alu_op),
    .i_operand_a (i_rs1),
    .i_operand_b (i_rs2),
    .i_imm       (i_imm),
    .i_pc        (i_pc),
    .i_use_imm   (i_use_imm),
    .i_writes_rd (i_writes_rd),
    .i_rd        (i_rd),
    .o_result    (alu_result),
    .o_rd_we     (rd_we)
  );

  // Resolves the branch and checks it against the fetch prediction
  branch_resolver branch_resolver_inst (
    .i_op          (i_branch_op),
    .i_rs1         (i_rs1),
    .i_rs2         (i_rs2),
    .i_pc          (i_pc),
    .i_imm         (i_imm),
    .i_pred_target (i_pred_target),
    .i_pred_taken  (i_pred_taken),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  store_unit store_unit_inst (
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_imm      (i_imm),
    .i_is_store (i_is_store),
    .i_size     (i_mem_size),
    .o_addr     (mem_addr),
    .o_wdata    (o_mem_wdata),
    .o_be       (o_mem_be)
  );

  // Alignment is judged on the effective address from the store unit
  exception_detector exception_detector_inst (
    .i_is_ecall  (i_is_ecall),
    .i_is_ebreak (i_is_ebreak),
    .i_is_load   (i_is_load),
    .i_is_store  (i_is_store),
    .i_size      (i_mem_size),
    .i_pc        (i_pc),
    .i_addr      (mem_addr),
    .o_valid     (o_exc_valid),
    .o_cause     (o_exc_cause),
    .o_tval      (o_exc_tval)
  );

  assign o_mem_addr = mem_addr;

  // ==========================================================
  // MA pipeline register
  // ==========================================================

  always_ff @(posedge i_clk) begin
    // Flush wins over stall and turns the slot into a bubble
    if (i_rst || i_flush) begin
      o_ma_rd_we         <= 1'b0;
      o_ma_is_load       <= 1'b0;
      o_ma_rd            <= `EX_RST_RD;
      o_ma_instr         <= `EX_NOP;
      o_ma_mem_size      <= ex_pkg::BYTE;
      o_ma_load_unsigned <= 1'b0;
    end else if (!i_stall) begin
      o_ma_rd_we         <= rd_we;
      o_ma_is_load       <= i_is_load;
      o_ma_rd            <= i_rd;
      o_ma_instr         <= i_instr;
      o_ma_mem_size      <= i_mem_size;
      o_ma_load_unsigned <= i_load_unsigned;
    end
    // Datapath fields follow the stall only
    if (!i_stall) begin
      o_ma_result   <= alu_result;
      o_ma_mem_addr <= mem_addr;
      // Forwarded rs2 for the memory stage
      o_ma_rs2      <= i_rs2;
    end
  end

endmodule : ex_stage

/* tests/ex_stage_assertions.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage_assertions (
  input logic                  i_clk,
  input logic                  i_rst,
  input logic                  i_stall,
  input logic                  i_flush,
  input logic                  i_is_store,
  input logic [`EX_BYTES-1:0]  o_mem_be,
  input logic                  o_exc_valid,
  input ex_pkg::exc_cause_t    o_exc_cause,
  input logic [`EX_XLEN-1:0]   o_ma_result,
  input logic [`EX_XLEN-1:0]   o_ma_mem_addr,
  input logic [`EX_XLEN-1:0]   o_ma_rs2,
  input logic [`EX_XLEN-1:0]   o_ma_instr,
  input logic                  o_ma_rd_we,
  input logic                  o_ma_is_load,
  input logic                  o_ma_load_unsigned,
  input logic [`EX_REG_W-1:0]  o_ma_rd,
  input ex_pkg::mem_size_t     o_ma_mem_size
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // ============================================================
  // MA register
  // ============================================================

  // Reset or flush leaves a bubble in the slot
  clear_on_flush: assert property (@(posedge i_clk)
    (i_rst || i_flush) |=>
      (!o_ma_rd_we && !o_ma_is_load && o_ma_instr == `EX_NOP && o_ma_rd == '0))
    else begin
      fail_count++;
      $error("MA control fields not cleared after reset or flush");
    end

  // Stall alone freezes every field
  hold_on_stall: assert property (@(posedge i_clk)
    (i_stall && !i_rst && !i_flush) |=>
      ($stable(o_ma_result) && $stable(o_ma_mem_addr) && $stable(o_ma_rs2) &&
       $stable(o_ma_instr) && $stable(o_ma_rd_we) && $stable(o_ma_rd) &&
       $stable(o_ma_is_load) && $stable(o_ma_mem_size) && $stable(o_ma_load_unsigned)))
    else begin
      fail_count++;
      $error("MA register changed while stalled");
    end

  // ============================================================
  // Same-cycle outputs
  // ============================================================

  be_only_on_store: assert property (@(posedge i_clk) !i_is_store |-> o_mem_be == '0)
    else begin
      fail_count++;
      $error("byte enables active without a store");
    end

  legal_cause: assert property (@(posedge i_clk)
    o_exc_valid |-> o_exc_cause inside {ex_pkg::BREAKPOINT, ex_pkg::LOAD_MISALIGNED,
                                        ex_pkg::STORE_MISALIGNED, ex_pkg::ECALL})
    else begin
      fail_count++;
      $error("exception raised with an unknown cause");
    end

endmodule : ex_stage_assertions

bind ex_stage ex_stage_assertions i_ex_stage_assertions (.*);

/* tests/ex_stage_tb.sv */
`timescale 1ns/1ps

`include "ex_macros.svh"

module ex_stage_tb;

  localparam int CLK_HALF     = 20;
  localparam int DRIVE_DELAY  = 2;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 20;
  localparam int WATCHDOG_NS  = 100000;

  logic                 i_clk, i_rst, i_use_imm, i_pred_taken, i_is_load, i_is_store;
  logic                 i_load_unsigned, i_is_ecall, i_is_ebreak, i_writes_rd;
  logic                 i_stall, i_flush;
  logic [`EX_XLEN-1:0]  i_pc, i_rs1, i_rs2, i_imm, i_pred_target, i_instr;
  logic [`EX_REG_W-1:0] i_rd;
  ex_pkg::alu_op_t      i_alu_op;
  ex_pkg::branch_op_t   i_branch_op;
  ex_pkg::mem_size_t    i_mem_size;
  logic                 o_redirect, o_exc_valid, o_ma_rd_we, o_ma_is_load, o_ma_load_unsigned;
  logic [`EX_XLEN-1:0]  o_redirect_pc, o_mem_addr, o_mem_wdata, o_exc_tval;
  logic [`EX_XLEN-1:0]  o_ma_result, o_ma_mem_addr, o_ma_rs2, o_ma_instr;
  logic [`EX_BYTES-1:0] o_mem_be;
  logic [`EX_REG_W-1:0] o_ma_rd;
  ex_pkg::exc_cause_t   o_exc_cause;
  ex_pkg::mem_size_t    o_ma_mem_size;

  // Running totals, plus marks taken at the start of each test
  int          checks = 0;
  int          errors = 0;
  int          mark_checks = 0;
  int          mark_errors = 0;
  int          assert_fails;
  logic [31:0] lfsr_state = 32'd86;

  ex_stage i_ex_stage (.*);

  initial begin
    i_clk = 1'b0;
    forever #CLK_HALF i_clk = ~i_clk;
  end

  // Hard limit on the whole run
  initial begin
    #WATCHDOG_NS;
    $display("watchdog expired before the test sequence finished");
    $display("Done: errors found");
    $finish;
  end

  // ============================================================
  // Helpers
  // ============================================================

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return bits;
  endfunction

  task automatic next_cycle();
    @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(string name);
    $display("test %-10s %0d checks, %0d errors", name, checks - mark_checks,
             errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  // Quiet instruction, no memory access, no trap, no control transfer
  task automatic idle_inputs();
    i_pc = '0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_imm = '0;
    i_use_imm = 1'b0;
    i_alu_op = ex_pkg::ADD;
    i_branch_op = ex_pkg::NONE;
    i_pred_taken = 1'b0;
    i_pred_target = '0;
    {i_is_load, i_is_store, i_load_unsigned, i_is_ecall, i_is_ebreak} = '0;
    i_mem_size = ex_pkg::WORD;
    i_rd = '0;
    i_writes_rd = 1'b0;
    i_instr = `EX_NOP;
    i_stall = 1'b0;
    i_flush = 1'b0;
  endtask

  // Random ADD into a nonzero destination
  task automatic random_add();
    i_alu_op = ex_pkg::ADD;
    i_use_imm = 1'b0;
    i_rs1 = take_bits(32);
    i_rs2 = take_bits(32);
    i_imm = take_bits(12);
    i_rd = take_bits(4) + 1;
    i_writes_rd = 1'b1;
    i_is_load = take_bits(1);
    // Load size and sign also travel down the pipe
    i_mem_size = ex_pkg::mem_size_t'(take_bits(2) % 3);
    i_load_unsigned = take_bits(1);
    i_instr = take_bits(32);
  endtask

  // ============================================================
  // Reference rules
  // ============================================================

  // Signed compare from the sign bits first
  function automatic logic signed_less(logic [31:0] a, logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [31:0] alu_model(ex_pkg::alu_op_t op, logic [31:0] a,
                                            logic [31:0] b, logic [31:0] pc,
                                            logic [31:0] imm);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ex_pkg::ADD:   return a + b;
      ex_pkg::SUB:   return a + ~b + 32'd1;
      ex_pkg::SLL:   return a << sh;
      ex_pkg::SLT:   return {31'd0, signed_less(a, b)};
      ex_pkg::SLTU:  return {31'd0, a < b};
      ex_pkg::XOR:   return a ^ b;
      ex_pkg::SRL:   return a >> sh;
      // Fill the vacated upper bits with the sign
      ex_pkg::SRA:   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
      ex_pkg::OR:    return a | b;
      ex_pkg::AND:   return a & b;
      ex_pkg::LUI:   return imm;
      ex_pkg::AUIPC: return pc + imm;
      ex_pkg::LINK:  return pc + 32'd4;
      default:       return 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(ex_pkg::branch_op_t op, logic [31:0] a,
                                        logic [31:0] b);
    case (op)
      ex_pkg::BEQ:  return a == b;
      ex_pkg::BNE:  return a != b;
      ex_pkg::BLT:  return signed_less(a, b);
      ex_pkg::BGE:  return !signed_less(a, b);
      ex_pkg::BLTU: return a < b;
      ex_pkg::BGEU: return a >= b;
      ex_pkg::JAL:  return 1'b1;
      ex_pkg::JALR: return 1'b1;
      default:      return 1'b0;
    endcase
  endfunction

  // Lane by lane view of the store rules
  function automatic logic [3:0] be_model(ex_pkg::mem_size_t size, logic [31:0] addr,
                                          logic store);
    logic [3:0] be;
    for (int j = 0; j < 4; j++) begin
      case (size)
        ex_pkg::BYTE: be[j] = (addr[1:0] == j);
        ex_pkg::HALF: be[j] = (addr[1] == j / 2);
        default:      be[j] = 1'b1;
      endcase
    end
    return store ? be : 4'b0000;
  endfunction

  function automatic logic [31:0] wdata_model(ex_pkg::mem_size_t size, logic [31:0] data);
    logic [31:0] w;
    for (int j = 0; j < 4; j++) begin
      case (size)
        ex_pkg::BYTE: w[8*j +: 8] = data[7:0];
        ex_pkg::HALF: w[8*j +: 8] = data[8*(j%2) +: 8];
        default:      w[8*j +: 8] = data[8*j +: 8];
      endcase
    end
    return w;
  endfunction

  // ============================================================
  // Tests
  // ============================================================

  task automatic test_reset_flush();
    int n;
    n = 0;
    // Empty slot must show up within a bounded number of cycles
    while (o_ma_instr !== `EX_NOP && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (o_ma_instr !== `EX_NOP) begin
      errors++;
      $display("timeout: MA register never held NOP during reset");
    end
    check("o_ma_rd_we", 0, o_ma_rd_we);
    check("o_ma_is_load", 0, o_ma_is_load);
    check("o_ma_instr", `EX_NOP, o_ma_instr);
    i_rst = 1'b0;
    random_add();
    i_is_load = 1'b1;
    next_cycle();
    check("o_ma_is_load", 1, o_ma_is_load);
    // Flush together with stall, flush has to win
    i_flush = 1'b1;
    i_stall = 1'b1;
    next_cycle();
    check("o_ma_rd_we", 0, o_ma_rd_we);
    check("o_ma_is_load", 0, o_ma_is_load);
    check("o_ma_instr", `EX_NOP, o_ma_instr);
    check("o_ma_rd", 0, o_ma_rd);
    i_flush = 1'b0;
    i_stall = 1'b0;
    end_test("reset");
  endtask

  task automatic test_alu();
    logic [31:0] exp;
    logic        exp_we;
    for (int k = 0; k <= 12; k++) begin
      for (int s = 0; s < 2; s++) begin
        i_alu_op = ex_pkg::alu_op_t'(k);
        i_use_imm = s[0];
        i_rs1 = take_bits(32);
        i_rs2 = take_bits(32);
        i_imm = take_bits(32);
        i_pc = take_bits(30) << 2;
        i_rd = (k % 4 == 0 && s == 1) ? '0 : take_bits(5);
        i_writes_rd = take_bits(1);
        exp = alu_model(i_alu_op, i_rs1, i_use_imm ? i_imm : i_rs2, i_pc, i_imm);
        exp_we = i_writes_rd && (i_rd != '0);
        next_cycle();
        check("o_ma_result", exp, o_ma_result);
        check("o_ma_rd_we", exp_we, o_ma_rd_we);
      end
    end
    end_test("alu");
  endtask

  task automatic test_branch();
    logic [31:0] raw;
    logic [31:0] target;
    logic        taken;
    for (int k = 0; k <= 8; k++) begin
      for (int r = 0; r < 4; r++) begin
        i_branch_op = ex_pkg::branch_op_t'(k);
        i_rs1 = take_bits(32);
        // Equal operands on odd rounds so BEQ and BNE see both outcomes
        i_rs2 = r[0] ? i_rs1 : take_bits(32);
        i_pc = take_bits(30) << 2;
        raw = take_bits(13);
        i_imm = {{19{raw[12]}}, raw[12:1], 1'b0};
        i_pred_taken = take_bits(1);
        taken = branch_taken(i_branch_op, i_rs1, i_rs2);
        if (i_branch_op == ex_pkg::JALR) begin
          target = (i_rs1 + i_imm) & ~32'd1;
        end else begin
          target = i_pc + i_imm;
        end
        i_pred_target = r[1] ? target : take_bits(32);
        #1;
        check("o_redirect",
              (taken != i_pred_taken) || (taken && i_pred_target != target), o_redirect);
        check("o_redirect_pc", taken ? target : i_pc + 32'd4, o_redirect_pc);
        next_cycle();
      end
    end
    i_branch_op = ex_pkg::NONE;
    i_pred_taken = 1'b0;
    end_test("branch");
  endtask

  task automatic test_store();
    logic [31:0] addr;
    for (int s = 0; s < 3; s++) begin
      for (int r = 0; r < 5; r++) begin
        i_mem_size = ex_pkg::mem_size_t'(s);
        // Last round of each size is a non-store
        i_is_store = (r != 4);
        i_rs1 = take_bits(32);
        i_imm = take_bits(12);
        i_rs2 = take_bits(32);
        addr = i_rs1 + i_imm;
        #1;
        check("o_mem_addr", addr, o_mem_addr);
        check("o_mem_be", be_model(i_mem_size, addr, i_is_store), o_mem_be);
        check("o_mem_wdata", wdata_model(i_mem_size, i_rs2), o_mem_wdata);
        next_cycle();
      end
    end
    i_is_store = 1'b0;
    end_test("store");
  endtask

  task automatic test_exceptions();
    logic [31:0] addr;
    logic        mis;
    logic        valid;
    logic [31:0] cause;
    logic [31:0] tval;
    for (int c = 0; c < 32; c++) begin
      {i_is_ecall, i_is_ebreak, i_is_load, i_is_store} = c[3:0];
      i_mem_size = ex_pkg::mem_size_t'(take_bits(2) % 3);
      i_rs1 = take_bits(32);
      i_imm = take_bits(12);
      i_pc = take_bits(30) << 2;
      addr = i_rs1 + i_imm;
      mis = (i_mem_size == ex_pkg::HALF && addr[0]) ||
            (i_mem_size == ex_pkg::WORD && addr[1:0] != 2'b00);
      valid = 1'b1;
      tval = addr;
      if (i_is_ecall) begin
        cause = 11;
        tval = '0;
      end else if (i_is_ebreak) begin
        cause = 3;
        tval = i_pc;
      end else if (i_is_load && mis) begin
        cause = 4;
      end else if (i_is_store && mis) begin
        cause = 6;
      end else begin
        valid = 1'b0;
      end
      #1;
      check("o_exc_valid", valid, o_exc_valid);
      if (valid) begin
        check("o_exc_cause", cause, o_exc_cause);
        check("o_exc_tval", tval, o_exc_tval);
      end
      next_cycle();
    end
    {i_is_ecall, i_is_ebreak, i_is_load, i_is_store} = '0;
    end_test("exception");
  endtask

  task automatic test_stall();
    logic [31:0] held_result;
    logic [31:0] held_instr;
    logic [31:0] held_rs2;
    logic [4:0]  held_rd;
    logic [31:0] exp;
    random_add();
    next_cycle();
    held_result = o_ma_result;
    held_instr = o_ma_instr;
    held_rs2 = o_ma_rs2;
    held_rd = o_ma_rd;
    i_stall = 1'b1;
    // Inputs keep moving while the register is frozen
    for (int k = 0; k < 3; k++) begin
      random_add();
      next_cycle();
      check("o_ma_result", held_result, o_ma_result);
      check("o_ma_instr", held_instr, o_ma_instr);
      check("o_ma_rs2", held_rs2, o_ma_rs2);
      check("o_ma_rd", held_rd, o_ma_rd);
    end
    i_stall = 1'b0;
    random_add();
    exp = i_rs1 + i_rs2;
    next_cycle();
    check("o_ma_result", exp, o_ma_result);
    check("o_ma_instr", i_instr, o_ma_instr);
    check("o_ma_rs2", i_rs2, o_ma_rs2);
    check("o_ma_rd", i_rd, o_ma_rd);
    // Every other field of the slot is captured on the same edge
    check("o_ma_mem_addr", i_rs1 + i_imm, o_ma_mem_addr);
    check("o_ma_rd_we", i_writes_rd && (i_rd != '0), o_ma_rd_we);
    check("o_ma_is_load", i_is_load, o_ma_is_load);
    check("o_ma_mem_size", i_mem_size, o_ma_mem_size);
    check("o_ma_load_unsigned", i_load_unsigned, o_ma_load_unsigned);
    end_test("stall");
  endtask

  // ============================================================
  // Sequence
  // ============================================================

  initial begin
    idle_inputs();
    i_rst = 1'b1;
    for (int k = 0; k < RESET_CYCLES; k++) begin
      next_cycle();
    end
    test_reset_flush();
    test_alu();
    test_branch();
    test_store();
    test_exceptions();
    test_stall();
    next_cycle();
    assert_fails = i_ex_stage.i_ex_stage_assertions.fail_count;
    $display("total: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : ex_stage_tb

/* list.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/branch_resolver.sv
rtl/store_unit.sv
rtl/exception_detector.sv
rtl/ex_stage.sv
tests/ex_stage_assertions.sv
tests/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - rtl

sources:
  - rtl/ex_pkg.sv
  - rtl/ex_alu.sv
  - rtl/branch_resolver.sv
  - rtl/store_unit.sv
  - rtl/exception_detector.sv
  - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/ex_stage_assertions.sv
      - tests/ex_stage_tb.sv
